/* Makefile */
VERILATOR ?= verilator
TOP       ?= decode_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx 'TEST OK' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* project.f */
src/lc3b_pkg.sv
src/control_rom.sv
src/regfile.sv
src/hazard_detect.sv
src/decode_stage.sv
src/decode_top.sv
verification/decode_tb.sv

/* src/control_rom.sv */
`timescale 1ns/1ps

module control_rom (
	input  lc3b_pkg::lc3b_opcode opcode,
	input  logic                 imm_check,
	input  logic                 jsr_check,
	input  logic                 rshf_check,
	output lc3b_pkg::lc3b_aluop  aluop,
	output logic [1:0]           sr2mux_sel,
	output logic [1:0]           addr2mux_sel,
	output logic [1:0]           drmux_sel,
	output logic                 load_cc,
	output logic                 load_regfile,
	output logic                 branch_stall,
	output logic                 mem_read,
	output logic                 mem_write,
	output logic                 addr1mux_sel,
	output logic                 regfilemux_sel,
	output logic                 memaddrmux_sel,
	output logic                 destmux_sel,
	output logic                 indirectaddrmux_sel,
	output logic                 sr1_needed,
	output logic                 sr2_needed,
	output logic                 lshf_enable
);

	always_comb begin
		aluop               = lc3b_pkg::alu_pass;
		sr2mux_sel          = 2'b00;
		addr2mux_sel        = 2'b00;
		drmux_sel           = 2'b00;
		load_cc             = 1'b0;
		load_regfile        = 1'b0;
		branch_stall        = 1'b0;
		mem_read            = 1'b0;
		mem_write           = 1'b0;
		addr1mux_sel        = 1'b0;
		regfilemux_sel      = 1'b0;
		memaddrmux_sel      = 1'b0;
		destmux_sel         = 1'b0;
		indirectaddrmux_sel = 1'b0;
		sr1_needed          = 1'b0;
		sr2_needed          = 1'b0;
		lshf_enable         = 1'b0;

		case (opcode)
			// bit 5 picks the immediate or the second source register
			lc3b_pkg::op_add, lc3b_pkg::op_and: begin
				aluop          = (opcode == lc3b_pkg::op_add) ? lc3b_pkg::alu_add
				                                             : lc3b_pkg::alu_and;
				sr1_needed     = 1'b1;
				sr2_needed     = !imm_check;
				sr2mux_sel     = imm_check ? 2'b01 : 2'b00;
				load_regfile   = 1'b1;
				load_cc        = 1'b1;
				drmux_sel      = 2'b11;
				regfilemux_sel = 1'b1;
			end
			lc3b_pkg::op_not: begin
				aluop        = lc3b_pkg::alu_not;
				sr1_needed   = 1'b1;
				load_regfile = 1'b1;
				load_cc      = 1'b1;
				drmux_sel    = 2'b11;
			end
			lc3b_pkg::op_shf: begin
				// bit 4 selects a right shift, then bit 5 makes it arithmetic
				if (!rshf_check)
					aluop = lc3b_pkg::alu_sll;
				else if (!imm_check)
					aluop = lc3b_pkg::alu_srl;
				else
					aluop = lc3b_pkg::alu_sra;
				sr1_needed   = 1'b1;
				sr2mux_sel   = 2'b10;
				load_regfile = 1'b1;
				load_cc      = 1'b1;
				drmux_sel    = 2'b11;
			end
			lc3b_pkg::op_ldr, lc3b_pkg::op_ldi, lc3b_pkg::op_ldb: begin
				sr1_needed   = 1'b1;
				mem_read     = 1'b1;
				load_regfile = 1'b1;
				load_cc      = 1'b1;
				addr1mux_sel = 1'b1;
				addr2mux_sel = 2'b01;
				drmux_sel    = 2'b01;
				lshf_enable  = (opcode == lc3b_pkg::op_ldb);
			end
			lc3b_pkg::op_str, lc3b_pkg::op_stb: begin
				sr1_needed   = 1'b1;
				mem_write    = 1'b1;
				addr1mux_sel = 1'b1;
				addr2mux_sel = 2'b01;
				lshf_enable  = (opcode == lc3b_pkg::op_stb);
			end
			lc3b_pkg::op_sti: begin
				// first access of STI reads the pointer
				sr1_needed   = 1'b1;
				mem_read     = 1'b1;
				addr1mux_sel = 1'b1;
				addr2mux_sel = 2'b01;
			end
			lc3b_pkg::op_br: begin
				addr2mux_sel = 2'b10;
			end
			lc3b_pkg::op_lea: begin
				addr2mux_sel = 2'b10;
				load_regfile = 1'b1;
				load_cc      = 1'b1;
			end
			lc3b_pkg::op_jmp: begin
				sr1_needed   = 1'b1;
				addr1mux_sel = 1'b1;
			end
			lc3b_pkg::op_jsr: begin
				// bit 11 clear is JSRR, the target comes from a register
				destmux_sel  = 1'b1;
				load_regfile = 1'b1;
				drmux_sel    = 2'b10;
				sr1_needed   = !jsr_check;
				addr1mux_sel = !jsr_check;
				addr2mux_sel = jsr_check ? 2'b11 : 2'b00;
			end
			lc3b_pkg::op_trap: begin
				destmux_sel    = 1'b1;
				load_regfile   = 1'b1;
				drmux_sel      = 2'b10;
				memaddrmux_sel = 1'b1;
				mem_read       = 1'b1;
			end
			default: begin
				// RTI and anything unknown decode to an empty control word
				aluop = '0;
			end
		endcase
	end

	always_comb begin
		assert (!(mem_read && mem_write))
			else $error("control_rom: read and write decoded together");
	end

endmodule : control_rom

/* src/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 id_valid,
	input  logic                 stall,
	input  lc3b_pkg::lc3b_word   instr,
	input  lc3b_pkg::lc3b_word   pc,
	input  logic                 destmux_sel,
	input  lc3b_pkg::lc3b_word   sr1_data,
	input  lc3b_pkg::lc3b_word   sr2_data,
	input  lc3b_pkg::lc3b_aluop  aluop,
	input  logic [1:0]           sr2mux_sel,
	input  logic [1:0]           addr2mux_sel,
	input  logic [1:0]           drmux_sel,
	input  logic                 load_cc,
	input  logic                 load_regfile,
	input  logic                 branch_stall,
	input  logic                 mem_read,
	input  logic                 mem_write,
	input  logic                 addr1mux_sel,
	input  logic                 regfilemux_sel,
	input  logic                 memaddrmux_sel,
	input  logic                 indirectaddrmux_sel,
	input  logic                 lshf_enable,
	output logic                 ex_valid,
	output lc3b_pkg::lc3b_opcode ex_opcode,
	output lc3b_pkg::lc3b_aluop  ex_aluop,
	output logic                 ex_load_cc,
	output logic                 ex_load_regfile,
	output logic                 ex_branch_stall,
	output logic                 ex_mem_read,
	output logic                 ex_mem_write,
	output logic [1:0]           ex_sr2mux_sel,
	output logic                 ex_addr1mux_sel,
	output logic [1:0]           ex_addr2mux_sel,
	output logic [1:0]           ex_drmux_sel,
	output logic                 ex_regfilemux_sel,
	output logic                 ex_memaddrmux_sel,
	output logic                 ex_indirectaddrmux_sel,
	output logic                 ex_lshf_enable,
	output lc3b_pkg::lc3b_reg    ex_dest,
	output lc3b_pkg::lc3b_word   ex_sr1_data,
	output lc3b_pkg::lc3b_word   ex_sr2_data,
	output lc3b_pkg::lc3b_word   ex_instr,
	output lc3b_pkg::lc3b_word   ex_pc
);

	logic              load_en;
	lc3b_pkg::lc3b_reg dest;

	assign load_en = id_valid && !stall;

	// JSR and TRAP link through R7
	assign dest = destmux_sel ? lc3b_pkg::lc3b_reg'(7) : instr[11:9];

	// ======================================================================
	// control half is zeroed on reset and on every bubble
	// ======================================================================

	always_ff @(posedge clk) begin
		if (reset || !load_en) begin
			ex_valid               <= 1'b0;
			ex_opcode              <= '0;
			ex_aluop               <= '0;
			ex_load_cc             <= 1'b0;
			ex_load_regfile        <= 1'b0;
			ex_branch_stall        <= 1'b0;
			ex_mem_read            <= 1'b0;
			ex_mem_write           <= 1'b0;
			ex_sr2mux_sel          <= '0;
			ex_addr1mux_sel        <= 1'b0;
			ex_addr2mux_sel        <= '0;
			ex_drmux_sel           <= '0;
			ex_regfilemux_sel      <= 1'b0;
			ex_memaddrmux_sel      <= 1'b0;
			ex_indirectaddrmux_sel <= 1'b0;
			ex_lshf_enable         <= 1'b0;
		end else begin
			ex_valid               <= 1'b1;
			ex_opcode              <= instr[15:12];
			ex_aluop               <= aluop;
			ex_load_cc             <= load_cc;
			ex_load_regfile        <= load_regfile;
			ex_branch_stall        <= branch_stall;
			ex_mem_read            <= mem_read;
			ex_mem_write           <= mem_write;
			ex_sr2mux_sel          <= sr2mux_sel;
			ex_addr1mux_sel        <= addr1mux_sel;
			ex_addr2mux_sel        <= addr2mux_sel;
			ex_drmux_sel           <= drmux_sel;
			ex_regfilemux_sel      <= regfilemux_sel;
			ex_memaddrmux_sel      <= memaddrmux_sel;
			ex_indirectaddrmux_sel <= indirectaddrmux_sel;
			ex_lshf_enable         <= lshf_enable;
		end
	end

	// ======================================================================
	// payload half only matters while ex_valid is high
	// ======================================================================

	always_ff @(posedge clk) begin
		if (load_en) begin
			ex_instr    <= instr;
			ex_pc       <= pc;
			ex_dest     <= dest;
			ex_sr1_data <= sr1_data;
			ex_sr2_data <= sr2_data;
		end
	end

	// a stalled instruction must still be in decode when the stall drops
	stall_holds_fetch: assert property (
		@(posedge clk) disable iff (reset)
		stall |=> ($stable(instr) && $stable(pc) && $stable(id_valid))
	) else $error("decode_stage: fetch changed its slot during a stall");

endmodule : decode_stage

/* src/decode_top.sv */
`timescale 1ns/1ps

module decode_top (
	input  logic                 clk,
	input  logic                 reset,
	input  lc3b_pkg::lc3b_word   instr,
	input  lc3b_pkg::lc3b_word   pc,
	input  logic                 id_valid,
	input  logic                 wb_enable,
	input  lc3b_pkg::lc3b_reg    wb_reg,
	input  lc3b_pkg::lc3b_word   wb_data,
	output logic                 stall,
	output logic                 ex_valid,
	output lc3b_pkg::lc3b_opcode ex_opcode,
	output lc3b_pkg::lc3b_aluop  ex_aluop,
	output logic                 ex_load_cc,
	output logic                 ex_load_regfile,
	output logic                 ex_branch_stall,
	output logic                 ex_mem_read,
	output logic                 ex_mem_write,
	output logic [1:0]           ex_sr2mux_sel,
	output logic                 ex_addr1mux_sel,
	output logic [1:0]           ex_addr2mux_sel,
	output logic [1:0]           ex_drmux_sel,
	output logic                 ex_regfilemux_sel,
	output logic                 ex_memaddrmux_sel,
	output logic                 ex_indirectaddrmux_sel,
	output logic                 ex_lshf_enable,
	output lc3b_pkg::lc3b_reg    ex_dest,
	output lc3b_pkg::lc3b_word   ex_sr1_data,
	output lc3b_pkg::lc3b_word   ex_sr2_data,
	output lc3b_pkg::lc3b_word   ex_instr,
	output lc3b_pkg::lc3b_word   ex_pc
);

	lc3b_pkg::lc3b_opcode opcode;
	lc3b_pkg::lc3b_reg    sr1;
	lc3b_pkg::lc3b_reg    sr2;
	lc3b_pkg::lc3b_word   sr1_data;
	lc3b_pkg::lc3b_word   sr2_data;
	lc3b_pkg::lc3b_aluop  aluop;
	logic [1:0]           sr2mux_sel;
	logic [1:0]           addr2mux_sel;
	logic [1:0]           drmux_sel;
	logic                 load_cc;
	logic                 load_regfile;
	logic                 branch_stall;
	logic                 mem_read;
	logic                 mem_write;
	logic                 addr1mux_sel;
	logic                 regfilemux_sel;
	logic                 memaddrmux_sel;
	logic                 destmux_sel;
	logic                 indirectaddrmux_sel;
	logic                 sr1_needed;
	logic                 sr2_needed;
	logic                 lshf_enable;

	assign opcode = instr[15:12];
	assign sr1    = instr[8:6];
	assign sr2    = instr[2:0];

	control_rom u_control_rom (
		.opcode              (opcode),
		.imm_check           (instr[5]),
		.jsr_check           (instr[11]),
		.rshf_check          (instr[4]),
		.aluop               (aluop),
		.sr2mux_sel          (sr2mux_sel),
		.addr2mux_sel        (addr2mux_sel),
		.drmux_sel           (drmux_sel),
		.load_cc             (load_cc),
		.load_regfile        (load_regfile),
		.branch_stall        (branch_stall),
		.mem_read            (mem_read),
		.mem_write           (mem_write),
		.addr1mux_sel        (addr1mux_sel),
		.regfilemux_sel      (regfilemux_sel),
		.memaddrmux_sel      (memaddrmux_sel),
		.destmux_sel         (destmux_sel),
		.indirectaddrmux_sel (indirectaddrmux_sel),
		.sr1_needed          (sr1_needed),
		.sr2_needed          (sr2_needed),
		.lshf_enable         (lshf_enable)
	);

	regfile u_regfile (
		.clk       (clk),
		.reset     (reset),
		.wb_enable (wb_enable),
		.wb_reg    (wb_reg),
		.wb_data   (wb_data),
		.sr1       (sr1),
		.sr2       (sr2),
		.sr1_data  (sr1_data),
		.sr2_data  (sr2_data)
	);

	hazard_detect u_hazard_detect (
		.id_valid        (id_valid),
		.sr1             (sr1),
		.sr2             (sr2),
		.sr1_needed      (sr1_needed),
		.sr2_needed      (sr2_needed),
		.ex_valid        (ex_valid),
		.ex_mem_read     (ex_mem_read),
		.ex_load_regfile (ex_load_regfile),
		.ex_dest         (ex_dest),
		.stall           (stall)
	);

	decode_stage u_decode_stage (
		.clk                    (clk),
		.reset                  (reset),
		.id_valid               (id_valid),
		.stall                  (stall),
		.instr                  (instr),
		.pc                     (pc),
		.destmux_sel            (destmux_sel),
		.sr1_data               (sr1_data),
		.sr2_data               (sr2_data),
		.aluop                  (aluop),
		.sr2mux_sel             (sr2mux_sel),
		.addr2mux_sel           (addr2mux_sel),
		.drmux_sel              (drmux_sel),
		.load_cc                (load_cc),
		.load_regfile           (load_regfile),
		.branch_stall           (branch_stall),
		.mem_read               (mem_read),
		.mem_write              (mem_write),
		.addr1mux_sel           (addr1mux_sel),
		.regfilemux_sel         (regfilemux_sel),
		.memaddrmux_sel         (memaddrmux_sel),
		.indirectaddrmux_sel    (indirectaddrmux_sel),
		.lshf_enable            (lshf_enable),
		.ex_valid               (ex_valid),
		.ex_opcode              (ex_opcode),
		.ex_aluop               (ex_aluop),
		.ex_load_cc             (ex_load_cc),
		.ex_load_regfile        (ex_load_regfile),
		.ex_branch_stall        (ex_branch_stall),
		.ex_mem_read            (ex_mem_read),
		.ex_mem_write           (ex_mem_write),
		.ex_sr2mux_sel          (ex_sr2mux_sel),
		.ex_addr1mux_sel        (ex_addr1mux_sel),
		.ex_addr2mux_sel        (ex_addr2mux_sel),
		.ex_drmux_sel           (ex_drmux_sel),
		.ex_regfilemux_sel      (ex_regfilemux_sel),
		.ex_memaddrmux_sel      (ex_memaddrmux_sel),
		.ex_indirectaddrmux_sel (ex_indirectaddrmux_sel),
		.ex_lshf_enable         (ex_lshf_enable),
		.ex_dest                (ex_dest),
		.ex_sr1_data            (ex_sr1_data),
		.ex_sr2_data            (ex_sr2_data),
		.ex_instr               (ex_instr),
		.ex_pc                  (ex_pc)
	);

endmodule : decode_top

/* src/hazard_detect.sv */
`timescale 1ns/1ps

module hazard_detect (
	input  logic              id_valid,
	input  lc3b_pkg::lc3b_reg sr1,
	input  lc3b_pkg::lc3b_reg sr2,
	input  logic              sr1_needed,
	input  logic              sr2_needed,
	input  logic              ex_valid,
	input  logic              ex_mem_read,
	input  logic              ex_load_regfile,
	input  lc3b_pkg::lc3b_reg ex_dest,
	output logic              stall
);

	logic ex_is_load;
	logic sr1_hit;
	logic sr2_hit;

	// the loaded value is not ready until after execute
	assign ex_is_load = ex_valid && ex_mem_read && ex_load_regfile;

	assign sr1_hit = sr1_needed && (ex_dest == sr1);
	assign sr2_hit = sr2_needed && (ex_dest == sr2);

	assign stall = id_valid && ex_is_load && (sr1_hit || sr2_hit);

endmodule : hazard_detect

/* src/lc3b_pkg.sv */
package lc3b_pkg;

	// ======================================================================
	// widths
	// ======================================================================

	localparam int word_width   = 16;
	localparam int opcode_width = 4;
	localparam int reg_width    = 3;
	localparam int aluop_width  = 3;

	// the register file has one entry per index value
	localparam int num_regs = 8;

	typedef logic [word_width-1:0]   lc3b_word;
	typedef logic [opcode_width-1:0] lc3b_opcode;
	typedef logic [reg_width-1:0]    lc3b_reg;
	typedef logic [aluop_width-1:0]  lc3b_aluop;

	// ======================================================================
	// opcodes, as encoded in instr[15:12]
	// ======================================================================

	localparam lc3b_opcode op_br   = 4'd0;
	localparam lc3b_opcode op_add  = 4'd1;
	localparam lc3b_opcode op_ldb  = 4'd2;
	localparam lc3b_opcode op_stb  = 4'd3;
	localparam lc3b_opcode op_jsr  = 4'd4;
	localparam lc3b_opcode op_and  = 4'd5;
	localparam lc3b_opcode op_ldr  = 4'd6;
	localparam lc3b_opcode op_str  = 4'd7;
	localparam lc3b_opcode op_rti  = 4'd8;
	localparam lc3b_opcode op_not  = 4'd9;
	localparam lc3b_opcode op_ldi  = 4'd10;
	localparam lc3b_opcode op_sti  = 4'd11;
	localparam lc3b_opcode op_jmp  = 4'd12;
	localparam lc3b_opcode op_shf  = 4'd13;
	localparam lc3b_opcode op_lea  = 4'd14;
	localparam lc3b_opcode op_trap = 4'd15;

	// ======================================================================
	// ALU operations
	// ======================================================================

	localparam lc3b_aluop alu_add  = 3'd0;
	localparam lc3b_aluop alu_and  = 3'd1;
	localparam lc3b_aluop alu_not  = 3'd2;
	localparam lc3b_aluop alu_pass = 3'd3;
	localparam lc3b_aluop alu_sll  = 3'd4;
	localparam lc3b_aluop alu_srl  = 3'd5;
	localparam lc3b_aluop alu_sra  = 3'd6;

endpackage : lc3b_pkg

/* src/regfile.sv */
`timescale 1ns/1ps

module regfile (
	input  logic               clk,
	input  logic               reset,
	input  logic               wb_enable,
	input  lc3b_pkg::lc3b_reg  wb_reg,
	input  lc3b_pkg::lc3b_word wb_data,
	input  lc3b_pkg::lc3b_reg  sr1,
	input  lc3b_pkg::lc3b_reg  sr2,
	output lc3b_pkg::lc3b_word sr1_data,
	output lc3b_pkg::lc3b_word sr2_data
);

	lc3b_pkg::lc3b_word regs [lc3b_pkg::num_regs];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < lc3b_pkg::num_regs; i++)
				regs[i] <= '0;
		end else if (wb_enable) begin
			regs[wb_reg] <= wb_data;
		end
	end

	// a write in the same cycle is forwarded so decode sees the new value
	assign sr1_data = (wb_enable && wb_reg == sr1) ? wb_data : regs[sr1];
	assign sr2_data = (wb_enable && wb_reg == sr2) ? wb_data : regs[sr2];

	wb_data_known: assert property (
		@(posedge clk) disable iff (reset)
		wb_enable |-> !$isunknown(wb_data)
	) else $error("regfile: write-back data has unknown bits");

endmodule : regfile

/* verification/decode_tb.sv */
`timescale 1ns/1ps

module decode_tb;

	localparam int clk_period   = 8;
	localparam int num_random   = 400;
	localparam int num_directed = 21;
	localparam int num_tests    = num_directed + 16 * 8 + num_random;
	// a test takes one cycle, or two when it stalls
	localparam int watchdog_ns  = (num_tests + 20) * 2 * clk_period;

	typedef struct packed {
		lc3b_pkg::lc3b_aluop aluop;
		logic [1:0]          sr2mux_sel;
		logic [1:0]          addr2mux_sel;
		logic [1:0]          drmux_sel;
		logic                load_cc;
		logic                load_regfile;
		logic                branch_stall;
		logic                mem_read;
		logic                mem_write;
		logic                addr1mux_sel;
		logic                regfilemux_sel;
		logic                memaddrmux_sel;
		logic                destmux_sel;
		logic                indirectaddrmux_sel;
		logic                sr1_needed;
		logic                sr2_needed;
		logic                lshf_enable;
	} ctrl_t;

	logic                 clk = 1'b0;
	logic                 reset;
	lc3b_pkg::lc3b_word   instr;
	lc3b_pkg::lc3b_word   pc;
	logic                 id_valid;
	logic                 wb_enable;
	lc3b_pkg::lc3b_reg    wb_reg;
	lc3b_pkg::lc3b_word   wb_data;
	logic                 stall;
	logic                 ex_valid;
	lc3b_pkg::lc3b_opcode ex_opcode;
	lc3b_pkg::lc3b_aluop  ex_aluop;
	logic                 ex_load_cc;
	logic                 ex_load_regfile;
	logic                 ex_branch_stall;
	logic                 ex_mem_read;
	logic                 ex_mem_write;
	logic [1:0]           ex_sr2mux_sel;
	logic                 ex_addr1mux_sel;
	logic [1:0]           ex_addr2mux_sel;
	logic [1:0]           ex_drmux_sel;
	logic                 ex_regfilemux_sel;
	logic                 ex_memaddrmux_sel;
	logic                 ex_indirectaddrmux_sel;
	logic                 ex_lshf_enable;
	lc3b_pkg::lc3b_reg    ex_dest;
	lc3b_pkg::lc3b_word   ex_sr1_data;
	lc3b_pkg::lc3b_word   ex_sr2_data;
	lc3b_pkg::lc3b_word   ex_instr;
	lc3b_pkg::lc3b_word   ex_pc;

	int                   seed = 32'h8374_a76c;
	int                   errors = 0;
	lc3b_pkg::lc3b_word   pc_next;
	lc3b_pkg::lc3b_word   model_regs [lc3b_pkg::num_regs];

	// expected content of the ID/EX register after the last edge
	ctrl_t                exp_c;
	logic                 exp_valid;
	lc3b_pkg::lc3b_opcode exp_opcode;
	lc3b_pkg::lc3b_reg    exp_dest;
	lc3b_pkg::lc3b_word   exp_sr1;
	lc3b_pkg::lc3b_word   exp_sr2;
	lc3b_pkg::lc3b_word   exp_instr;
	lc3b_pkg::lc3b_word   exp_pc;

	decode_top UUT (.*);

	always #(clk_period / 2) clk = ~clk;

	// ======================================================================
	// reference control table
	// ======================================================================

	function automatic ctrl_t decode_ref(input lc3b_pkg::lc3b_word ins);
		ctrl_t c;
		c = '0;
		c.aluop = lc3b_pkg::alu_pass;
		case (ins[15:12])
			lc3b_pkg::op_add, lc3b_pkg::op_and: begin
				c.aluop = (ins[15:12] == lc3b_pkg::op_add) ? lc3b_pkg::alu_add
				                                           : lc3b_pkg::alu_and;
				c.sr1_needed     = 1'b1;
				c.sr2_needed     = !ins[5];
				c.sr2mux_sel     = {1'b0, ins[5]};
				c.load_regfile   = 1'b1;
				c.load_cc        = 1'b1;
				c.drmux_sel      = 2'b11;
				c.regfilemux_sel = 1'b1;
			end
			lc3b_pkg::op_not, lc3b_pkg::op_shf: begin
				if (ins[15:12] == lc3b_pkg::op_not)
					c.aluop = lc3b_pkg::alu_not;
				else if (!ins[4])
					c.aluop = lc3b_pkg::alu_sll;
				else
					c.aluop = ins[5] ? lc3b_pkg::alu_sra : lc3b_pkg::alu_srl;
				c.sr2mux_sel   = (ins[15:12] == lc3b_pkg::op_shf) ? 2'b10 : 2'b00;
				c.sr1_needed   = 1'b1;
				c.load_regfile = 1'b1;
				c.load_cc      = 1'b1;
				c.drmux_sel    = 2'b11;
			end
			lc3b_pkg::op_ldr, lc3b_pkg::op_ldi, lc3b_pkg::op_ldb: begin
				c.sr1_needed   = 1'b1;
				c.mem_read     = 1'b1;
				c.load_regfile = 1'b1;
				c.load_cc      = 1'b1;
				c.addr1mux_sel = 1'b1;
				c.addr2mux_sel = 2'b01;
				c.drmux_sel    = 2'b01;
				c.lshf_enable  = (ins[15:12] == lc3b_pkg::op_ldb);
			end
			lc3b_pkg::op_str, lc3b_pkg::op_stb, lc3b_pkg::op_sti: begin
				c.sr1_needed   = 1'b1;
				c.mem_write    = (ins[15:12] != lc3b_pkg::op_sti);
				c.mem_read     = (ins[15:12] == lc3b_pkg::op_sti);
				c.addr1mux_sel = 1'b1;
				c.addr2mux_sel = 2'b01;
				c.lshf_enable  = (ins[15:12] == lc3b_pkg::op_stb);
			end
			lc3b_pkg::op_br: c.addr2mux_sel = 2'b10;
			lc3b_pkg::op_lea: begin
				c.addr2mux_sel = 2'b10;
				c.load_regfile = 1'b1;
				c.load_cc      = 1'b1;
			end
			lc3b_pkg::op_jmp: begin
				c.sr1_needed   = 1'b1;
				c.addr1mux_sel = 1'b1;
			end
			lc3b_pkg::op_jsr: begin
				c.destmux_sel  = 1'b1;
				c.load_regfile = 1'b1;
				c.drmux_sel    = 2'b10;
				c.sr1_needed   = !ins[11];
				c.addr1mux_sel = !ins[11];
				c.addr2mux_sel = ins[11] ? 2'b11 : 2'b00;
			end
			lc3b_pkg::op_trap: begin
				c.destmux_sel    = 1'b1;
				c.load_regfile   = 1'b1;
				c.drmux_sel      = 2'b10;
				c.memaddrmux_sel = 1'b1;
				c.mem_read       = 1'b1;
			end
			// RTI has no row and decodes to an empty word
			default: c = '0;
		endcase
		return c;
	endfunction

	function automatic lc3b_pkg::lc3b_word rr_instr(input lc3b_pkg::lc3b_opcode op,
			input lc3b_pkg::lc3b_reg dr, input lc3b_pkg::lc3b_reg s1,
			input lc3b_pkg::lc3b_reg s2);
		return {op, dr, s1, 3'b000, s2};
	endfunction

	function automatic lc3b_pkg::lc3b_word mem_instr(input lc3b_pkg::lc3b_opcode op,
			input lc3b_pkg::lc3b_reg dr, input lc3b_pkg::lc3b_reg base);
		return {op, dr, base, 6'd0};
	endfunction

	task automatic next_rand(output logic [31:0] r);
		r = $random(seed);
	endtask

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (actual === expected)
		else begin
			errors++;
			$display("FAILED %s expected %h actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic check_stall_count(input string what, input int expected, input int got);
		assert (got == expected)
		else begin
			errors++;
			$display("%s stalled for %0d cycle(s) instead of %0d", what, got, expected);
		end
	endtask

	task automatic check_outputs();
		check_value("ex_valid", 16'(exp_valid), 16'(ex_valid));
		check_value("ex_opcode", 16'(exp_opcode), 16'(ex_opcode));
		check_value("ex_aluop", 16'(exp_c.aluop), 16'(ex_aluop));
		check_value("ex_load_cc", 16'(exp_c.load_cc), 16'(ex_load_cc));
		check_value("ex_load_regfile", 16'(exp_c.load_regfile), 16'(ex_load_regfile));
		check_value("ex_branch_stall", 16'(exp_c.branch_stall), 16'(ex_branch_stall));
		check_value("ex_mem_read", 16'(exp_c.mem_read), 16'(ex_mem_read));
		check_value("ex_mem_write", 16'(exp_c.mem_write), 16'(ex_mem_write));
		check_value("ex_sr2mux_sel", 16'(exp_c.sr2mux_sel), 16'(ex_sr2mux_sel));
		check_value("ex_addr1mux_sel", 16'(exp_c.addr1mux_sel), 16'(ex_addr1mux_sel));
		check_value("ex_addr2mux_sel", 16'(exp_c.addr2mux_sel), 16'(ex_addr2mux_sel));
		check_value("ex_drmux_sel", 16'(exp_c.drmux_sel), 16'(ex_drmux_sel));
		check_value("ex_regfilemux_sel", 16'(exp_c.regfilemux_sel), 16'(ex_regfilemux_sel));
		check_value("ex_memaddrmux_sel", 16'(exp_c.memaddrmux_sel), 16'(ex_memaddrmux_sel));
		check_value("ex_indirectaddrmux_sel", 16'(exp_c.indirectaddrmux_sel),
			16'(ex_indirectaddrmux_sel));
		check_value("ex_lshf_enable", 16'(exp_c.lshf_enable), 16'(ex_lshf_enable));
		if (exp_valid) begin
			check_value("ex_dest", 16'(exp_dest), 16'(ex_dest));
			check_value("ex_sr1_data", exp_sr1, ex_sr1_data);
			check_value("ex_sr2_data", exp_sr2, ex_sr2_data);
			check_value("ex_instr", exp_instr, ex_instr);
			check_value("ex_pc", exp_pc, ex_pc);
		end
	endtask

	// drives one fetch slot and holds it for as long as the DUT stalls it
	task automatic issue(input lc3b_pkg::lc3b_word ins, input logic valid, input logic we,
			input lc3b_pkg::lc3b_reg wr, input lc3b_pkg::lc3b_word wd, output int stalls);
		stalls = 0;
		@(posedge clk);
		instr     <= ins;
		pc        <= pc_next;
		id_valid  <= valid;
		wb_enable <= we;
		wb_reg    <= wr;
		wb_data   <= wd;
		pc_next = pc_next + 16'd2;
		@(negedge clk);
		while (valid && stall) begin
			stalls++;
			@(posedge clk);
			wb_enable <= 1'b0;
			@(negedge clk);
		end
	endtask

	// ======================================================================
	// model updated at the edge and compared mid-cycle
	// ======================================================================

	initial begin : compare
		ctrl_t              cur;
		lc3b_pkg::lc3b_reg  s1;
		lc3b_pkg::lc3b_reg  s2;
		logic               ref_stall;
		logic               pend_reset;
		logic               pend_we;
		lc3b_pkg::lc3b_reg  pend_reg;
		lc3b_pkg::lc3b_word pend_data;
		lc3b_pkg::lc3b_word after_wb [lc3b_pkg::num_regs];
		pend_reset = 1'b1;
		pend_we    = 1'b0;
		pend_reg   = '0;
		pend_data  = '0;
		exp_valid  = 1'b0;
		exp_c      = '0;
		exp_opcode = '0;
		exp_dest   = '0;
		forever begin
			@(posedge clk);
			if (pend_reset) begin
				for (int i = 0; i < lc3b_pkg::num_regs; i++)
					model_regs[i] = '0;
			end else if (pend_we) begin
				model_regs[pend_reg] = pend_data;
			end
			@(negedge clk);
			check_outputs();

			cur = decode_ref(instr);
			s1  = instr[8:6];
			s2  = instr[2:0];
			ref_stall = id_valid && exp_valid && exp_c.mem_read && exp_c.load_regfile
				&& ((cur.sr1_needed && exp_dest == s1) || (cur.sr2_needed && exp_dest == s2));
			check_value("stall", 16'(ref_stall), 16'(stall));

			if (reset || !id_valid || ref_stall) begin
				exp_valid  = 1'b0;
				exp_c      = '0;
				exp_opcode = '0;
			end else begin
				exp_valid  = 1'b1;
				exp_c      = cur;
				exp_opcode = instr[15:12];
				exp_instr  = instr;
				exp_pc     = pc;
				// JSR and TRAP link into R7
				if (instr[15:12] == lc3b_pkg::op_jsr || instr[15:12] == lc3b_pkg::op_trap)
					exp_dest = 3'd7;
				else
					exp_dest = instr[11:9];
				// a read sees what the register will hold once this cycle's write lands
				after_wb = model_regs;
				if (wb_enable)
					after_wb[wb_reg] = wb_data;
				exp_sr1 = after_wb[s1];
				exp_sr2 = after_wb[s2];
			end

			pend_reset = reset;
			pend_we    = wb_enable;
			pend_reg   = wb_reg;
			pend_data  = wb_data;
		end
	end

	// ======================================================================
	// stimulus
	// ======================================================================

	initial begin : stimulus
		lc3b_pkg::lc3b_word ins;
		logic [31:0]        rnd;
		int                 stalls;
		pc_next = 16'h3000;
		reset     <= 1'b1;
		instr     <= '0;
		pc        <= '0;
		id_valid  <= 1'b0;
		wb_enable <= 1'b0;
		wb_reg    <= '0;
		wb_data   <= '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		for (int r = 0; r < lc3b_pkg::num_regs; r++) begin
			next_rand(rnd);
			issue(16'h0000, 1'b0, 1'b1, r[2:0], rnd[15:0], stalls);
		end

		// write-back into a source register in the same cycle
		issue(rr_instr(lc3b_pkg::op_add, 3'd5, 3'd1, 3'd2), 1'b1, 1'b1, 3'd1, 16'hbeef, stalls);
		issue(rr_instr(lc3b_pkg::op_and, 3'd6, 3'd3, 3'd2), 1'b1, 1'b1, 3'd2, 16'h1234, stalls);
		issue(rr_instr(lc3b_pkg::op_add, 3'd7, 3'd4, 3'd4), 1'b1, 1'b1, 3'd4, 16'h0f0f, stalls);

		issue(mem_instr(lc3b_pkg::op_ldr, 3'd3, 3'd1), 1'b1, 1'b0, 3'd0, 16'h0, stalls);
		issue(rr_instr(lc3b_pkg::op_add, 3'd4, 3'd3, 3'd2), 1'b1, 1'b0, 3'd0, 16'h0, stalls);
		check_stall_count("ADD after LDR into its sr1", 1, stalls);
		issue(mem_instr(lc3b_pkg::op_ldb, 3'd5, 3'd1), 1'b1, 1'b0, 3'd0, 16'h0, stalls);
		issue(rr_instr(lc3b_pkg::op_and, 3'd6, 3'd1, 3'd5), 1'b1, 1'b0, 3'd0, 16'h0, stalls);
		check_stall_count("AND after LDB into its sr2", 1, stalls);
		issue(mem_instr(lc3b_pkg::op_ldi, 3'd2, 3'd1), 1'b1, 1'b0, 3'd0, 16'h0, stalls);
		issue(rr_instr(lc3b_pkg::op_not, 3'd0, 3'd2, 3'd7), 1'b1, 1'b0, 3'd0, 16'h0, stalls);
		check_stall_count("NOT after LDI into its source", 1, stalls);
		issue(mem_instr(lc3b_pkg::op_ldr, 3'd3, 3'd1), 1'b1, 1'b0, 3'd0, 16'h0, stalls);
		issue(rr_instr(lc3b_pkg::op_add, 3'd4, 3'd1, 3'd2), 1'b1, 1'b0, 3'd0, 16'h0, stalls);
		check_stall_count("independent ADD after LDR", 0, stalls);
		issue(rr_instr(lc3b_pkg::op_add, 3'd3, 3'd1, 3'd2), 1'b1, 1'b0, 3'd0, 16'h0, stalls);
		issue(rr_instr(lc3b_pkg::op_add, 3'd4, 3'd3, 3'd2), 1'b1, 1'b0, 3'd0, 16'h0, stalls);
		check_stall_count("ADD after a non-load producer", 0, stalls);

		// every opcode with every setting of bits 11, 5 and 4
		for (int op = 0; op < 16; op++) begin
			for (int b = 0; b < 8; b++) begin
				next_rand(rnd);
				ins = rnd[15:0];
				ins[15:12] = op[3:0];
				ins[11] = b[2];
				ins[5]  = b[1];
				ins[4]  = b[0];
				issue(ins, 1'b1, 1'b0, 3'd0, 16'h0, stalls);
			end
		end

		for (int n = 0; n < num_random; n++) begin
			next_rand(rnd);
			ins = rnd[15:0];
			next_rand(rnd);
			// about one slot in four is a gap in the fetch stream
			issue(ins, rnd[1:0] != 2'b00, rnd[2], rnd[5:3], rnd[31:16], stalls);
		end

		@(posedge clk);
		id_valid  <= 1'b0;
		wb_enable <= 1'b0;
		repeat (3) @(posedge clk);
		$display("decode_tb finished with %0d error(s)", errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin : watchdog
		#(watchdog_ns);
		$display("watchdog: the run did not finish within %0d ns", watchdog_ns);
		$display("TEST FAILED");
		$finish;
	end

endmodule : decode_tb
